// ==== hw/ros2_buf_pkg.sv ====
package ros2_buf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int RXBUF_AWIDTH = 10;
    localparam int TXBUF_AWIDTH = 6;
    localparam int RX_SIZE_WIDTH = 16;

    localparam logic [RXBUF_AWIDTH-1:0] RX_SIZE_WORD_ADDR = 10'd1; // Size header slot

    // Size ranges shown on the LEDs
    localparam logic [RX_SIZE_WIDTH-1:0] LED_RED_MAX = 16'd10;
    localparam logic [RX_SIZE_WIDTH-1:0] LED_GREEN_MAX = 16'd20;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Transmit side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int TXBUF_REL_PERIOD = 32; // Board build wants ~2**27
    localparam int TXBUF_CNT_W = $clog2(TXBUF_REL_PERIOD);
    localparam int TXBUF_MSG_WORDS = 5;

    localparam logic [31:0] txbuf_msg [TXBUF_MSG_WORDS] = '{
        32'h0a01_a8c0, // Dest IP 192.168.1.10
        32'h0457_04d2, // Ports 1111 / 1234
        32'h0000_0007, // Length
        32'h626f_6f66, // "foob"
        32'h000a_7261  // "ar\n"
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        OWNER_IP  = 1'b0,
        OWNER_CPU = 1'b1
    } owner_e;

    typedef enum logic [1:0] {
        GRANT_NONE = 2'b00,
        GRANT_IP   = 2'b01,
        GRANT_CPU  = 2'b10
    } app_grant_e;

    typedef struct packed {
        logic [RX_SIZE_WIDTH-1:0] rx_size; // Upper half
        logic [15:0]              rx_info;
    } rxbuf_hdr_t;

    // Payload word, or the size header at RX_SIZE_WORD_ADDR
    typedef union packed {
        logic [31:0] raw;
        rxbuf_hdr_t  hdr;
    } rxbuf_word_u;

    typedef struct packed {
        logic [RXBUF_AWIDTH-1:0] addr;
        logic                    we;
        rxbuf_word_u             wdata;
    } rxbuf_wr_t;

endpackage

// ==== hw/buf_owner_toggle.sv ====
`timescale 1ns/1ps

module buf_owner_toggle
    import ros2_buf_pkg::*;
#(
    parameter owner_e RESET_OWNER = OWNER_IP
) (
    input  logic clk,
    input  logic rst_n,
    input  logic ip_rel,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    owner_e owner_q;

    // Only the current owner may hand the buffer over
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= RESET_OWNER;
        end else begin
            case (owner_q)
                OWNER_IP: begin
                    if (ip_rel) owner_q <= OWNER_CPU;
                end
                OWNER_CPU: begin
                    if (cpu_rel) owner_q <= OWNER_IP;
                end
            endcase
        end
    end

    assign ip_grant  = (owner_q == OWNER_IP);
    assign cpu_grant = (owner_q == OWNER_CPU);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_grants_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        ip_grant != cpu_grant
    ) else $error("buf_owner_toggle: grants equal");

endmodule

// ==== hw/app_data_arbiter.sv ====
`timescale 1ns/1ps

module app_data_arbiter
    import ros2_buf_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic ip_req,
    input  logic ip_rel,
    input  logic cpu_req,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    app_grant_e state_q;
    app_grant_e state_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Grant FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;
        case (state_q)
            GRANT_NONE: begin
                if (ip_req) begin
                    state_d = GRANT_IP; // IP wins a tie
                end else if (cpu_req) begin
                    state_d = GRANT_CPU;
                end
            end
            GRANT_IP: begin
                if (ip_rel) state_d = GRANT_NONE;
            end
            GRANT_CPU: begin
                if (cpu_rel) state_d = GRANT_NONE;
            end
            default: state_d = GRANT_NONE; // Unused code
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= GRANT_NONE;
        end else begin
            state_q <= state_d;
        end
    end

    assign ip_grant  = (state_q == GRANT_IP);
    assign cpu_grant = (state_q == GRANT_CPU);

    a_no_double_grant: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ip_grant && cpu_grant)
    ) else $error("app_data_arbiter: both grants high");

endmodule

// ==== hw/rxbuf_host_agent.sv ====
`timescale 1ns/1ps

module rxbuf_host_agent
    import ros2_buf_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  rxbuf_wr_t rxbuf_wr,
    input  logic      cpu_grant,
    output logic      cpu_rel,
    output logic      led_r,
    output logic      led_g,
    output logic      led_b
);

    logic [RX_SIZE_WIDTH-1:0] last_size_q;
    logic                     size_wr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Buffer return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Host does nothing with the buffer, so give it straight back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_rel <= 1'b0;
        end else begin
            cpu_rel <= cpu_grant;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Size capture and LED decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign size_wr = rxbuf_wr.we && (rxbuf_wr.addr == RX_SIZE_WORD_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_size_q <= '0;
        end else if (size_wr) begin
            last_size_q <= rxbuf_wr.wdata.hdr.rx_size; // Header view of the word
        end
    end

    always_comb begin
        led_r = 1'b0;
        led_g = 1'b0;
        led_b = 1'b0;
        if (last_size_q == '0) begin
            // Nothing received yet
        end else if (last_size_q <= LED_RED_MAX) begin
            led_r = 1'b1;
        end else if (last_size_q <= LED_GREEN_MAX) begin
            led_g = 1'b1;
        end else begin
            led_b = 1'b1;
        end
    end

    a_led_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({led_r, led_g, led_b})
    ) else $error("rxbuf_host_agent: more than one LED lit");

endmodule

// ==== hw/txbuf_host_agent.sv ====
`timescale 1ns/1ps

module txbuf_host_agent
    import ros2_buf_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [TXBUF_AWIDTH-1:0] txbuf_addr,
    output logic                    cpu_rel,
    output logic [31:0]             txbuf_rdata
);

    logic [TXBUF_CNT_W-1:0] rel_cnt_q;
    logic                   cnt_last;
    logic [31:0]            rdata_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Release period
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign cnt_last = (rel_cnt_q == TXBUF_CNT_W'(TXBUF_REL_PERIOD - 1));

    // Free running, independent of who holds the buffer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rel_cnt_q <= '0;
        end else if (cnt_last) begin
            rel_cnt_q <= '0;
        end else begin
            rel_cnt_q <= rel_cnt_q + 1'b1;
        end
    end

    assign cpu_rel = cnt_last; // One pulse per period

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Message readout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        rdata_d = '0; // Past the table reads zero
        for (int i = 0; i < TXBUF_MSG_WORDS; i++) begin
            if (txbuf_addr == TXBUF_AWIDTH'(i)) begin
                rdata_d = txbuf_msg[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        txbuf_rdata <= rdata_d;
    end

    a_rel_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_rel |=> !cpu_rel
    ) else $error("txbuf_host_agent: cpu_rel held two cycles");

endmodule

// ==== hw/ros2_buf_host.sv ====
`timescale 1ns/1ps

module ros2_buf_host
    import ros2_buf_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Receive buffer, engine side
    input  rxbuf_wr_t               rxbuf_wr,
    input  logic                    rxbuf_ip_rel,
    output logic                    rxbuf_ip_grant,

    // Transmit buffer, engine side
    input  logic [TXBUF_AWIDTH-1:0] txbuf_addr,
    input  logic                    txbuf_ip_rel,
    output logic                    txbuf_ip_grant,
    output logic [31:0]             txbuf_rdata,

    // Application data block
    input  logic                    app_ip_req,
    input  logic                    app_ip_rel,
    input  logic                    app_cpu_req,
    input  logic                    app_cpu_rel,
    output logic                    app_ip_grant,
    output logic                    app_cpu_grant,

    output logic                    led_r,
    output logic                    led_g,
    output logic                    led_b
);

    logic rxbuf_cpu_grant;
    logic rxbuf_cpu_rel;
    logic txbuf_cpu_rel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Ownership arbiters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    buf_owner_toggle #(
        .RESET_OWNER(OWNER_IP)
    ) u_rxbuf_owner (
        .clk       (clk),
        .rst_n     (rst_n),
        .ip_rel    (rxbuf_ip_rel),
        .cpu_rel   (rxbuf_cpu_rel),
        .ip_grant  (rxbuf_ip_grant),
        .cpu_grant (rxbuf_cpu_grant)
    );

    // Host owns it first and fills it from the table
    buf_owner_toggle #(
        .RESET_OWNER(OWNER_CPU)
    ) u_txbuf_owner (
        .clk       (clk),
        .rst_n     (rst_n),
        .ip_rel    (txbuf_ip_rel),
        .cpu_rel   (txbuf_cpu_rel),
        .ip_grant  (txbuf_ip_grant),
        .cpu_grant ()            // Agent releases on its own timer
    );

    app_data_arbiter u_app_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .ip_req    (app_ip_req),
        .ip_rel    (app_ip_rel),
        .cpu_req   (app_cpu_req),
        .cpu_rel   (app_cpu_rel),
        .ip_grant  (app_ip_grant),
        .cpu_grant (app_cpu_grant)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Host agents
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    rxbuf_host_agent u_rx_agent (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxbuf_wr  (rxbuf_wr),
        .cpu_grant (rxbuf_cpu_grant),
        .cpu_rel   (rxbuf_cpu_rel),
        .led_r     (led_r),
        .led_g     (led_g),
        .led_b     (led_b)
    );

    txbuf_host_agent u_tx_agent (
        .clk         (clk),
        .rst_n       (rst_n),
        .txbuf_addr  (txbuf_addr),
        .cpu_rel     (txbuf_cpu_rel),
        .txbuf_rdata (txbuf_rdata)
    );

endmodule

// ==== tb/tb_ros2_buf_host.sv ====
`timescale 1ns/1ps

module tb_ros2_buf_host
    import ros2_buf_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam logic [15:0] EDGE_SIZES [5] = '{
        16'd0, LED_RED_MAX, LED_RED_MAX + 16'd1, LED_GREEN_MAX, LED_GREEN_MAX + 16'd1
    };

    logic                    clk = 1'b0;
    logic                    rst_n;
    rxbuf_wr_t               rxbuf_wr;
    logic                    rxbuf_ip_rel;
    logic                    rxbuf_ip_grant;
    logic [TXBUF_AWIDTH-1:0] txbuf_addr;
    logic                    txbuf_ip_rel;
    logic                    txbuf_ip_grant;
    logic [31:0]             txbuf_rdata;
    logic                    app_ip_req;
    logic                    app_ip_rel;
    logic                    app_cpu_req;
    logic                    app_cpu_rel;
    logic                    app_ip_grant;
    logic                    app_cpu_grant;
    logic                    led_r;
    logic                    led_g;
    logic                    led_b;

    int          errors = 0;
    int          rel_edges;                      // Edges since reset release
    logic [15:0] lfsr_q = 16'd4801;
    logic [15:0] last_size;                      // Last size written to the header slot
    logic [31:0] exp_rdata [2**TXBUF_AWIDTH];
    logic        size_write;
    logic        app_idle;

    ros2_buf_host i_dut (.*);

    initial begin
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    function automatic logic [2:0] led_pattern(input logic [15:0] size);
        if (size == '0) return 3'b000;
        if (size <= LED_RED_MAX) return 3'b100;
        if (size <= LED_GREEN_MAX) return 3'b010;
        return 3'b001;
    endfunction

    task automatic log_failure(input string what);
        errors++;
        $display("FAILED at %0t ns: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("Run over at %0t ns, error count %0d", $time, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic tick(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_rx_rel();
        rxbuf_ip_rel = 1'b1;
        tick(1);
        rxbuf_ip_rel = 1'b0;
    endtask

    task automatic pulse_tx_rel();
        txbuf_ip_rel = 1'b1;
        tick(1);
        txbuf_ip_rel = 1'b0;
    endtask

    task automatic wait_rx_grant();
        while (!rxbuf_ip_grant) @(negedge clk);
    endtask

    task automatic wait_tx_grant();
        while (!txbuf_ip_grant) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engine side stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_tx_phase();
        wait_tx_grant();                         // First hand-over, no engine release yet
        repeat (6) begin
            tick(1 + rand_bits(4));
            pulse_tx_rel();
            if (lfsr_step()) begin
                pulse_tx_rel();                  // Host holds it, must be ignored
            end
            wait_tx_grant();
        end
    endtask

    task automatic run_rx_phase();
        for (int n = 0; n < 16; n++) begin
            wait_rx_grant();
            tick(rand_bits(3));
            pulse_rx_rel();
            if (lfsr_step()) begin
                pulse_rx_rel();                  // Grant low here
            end
        end
        wait_rx_grant();
    endtask

    task automatic run_size_phase();
        for (int n = 0; n < 40; n++) begin
            rxbuf_wr.wdata.hdr.rx_info = 16'(rand_bits(16));
            if (n < 5) begin
                rxbuf_wr.addr              = RX_SIZE_WORD_ADDR;
                rxbuf_wr.we                = 1'b1;
                rxbuf_wr.wdata.hdr.rx_size = EDGE_SIZES[n];
            end else begin
                if (rand_bits(2) != 0) begin
                    rxbuf_wr.addr = RX_SIZE_WORD_ADDR;
                end else begin
                    rxbuf_wr.addr = RXBUF_AWIDTH'(rand_bits(RXBUF_AWIDTH));
                end
                rxbuf_wr.we                = lfsr_step();
                rxbuf_wr.wdata.hdr.rx_size = 16'(rand_bits(5));
            end
            tick(1);
            rxbuf_wr.we = 1'b0;
            tick(rand_bits(1));
        end
    endtask

    task automatic run_app_phase();
        repeat (300) begin
            app_ip_req  = lfsr_step();
            app_cpu_req = lfsr_step();
            app_ip_rel  = (rand_bits(2) == 3);
            app_cpu_rel = (rand_bits(2) == 3);
            tick(1);
        end
        app_ip_req  = 1'b0;
        app_cpu_req = 1'b0;
        app_ip_rel  = 1'b0;
        app_cpu_rel = 1'b0;
    endtask

    initial begin
        for (int i = 0; i < 2**TXBUF_AWIDTH; i++) begin
            exp_rdata[i] = '0;
        end
        for (int i = 0; i < TXBUF_MSG_WORDS; i++) begin
            exp_rdata[i] = txbuf_msg[i];
        end
    end

    always @(negedge clk) begin
        txbuf_addr <= txbuf_addr + TXBUF_AWIDTH'(1); // Sweeps the whole address range
    end

    initial begin
        rst_n        = 1'b0;
        rxbuf_wr     = '0;
        rxbuf_ip_rel = 1'b0;
        txbuf_addr   = '0;
        txbuf_ip_rel = 1'b0;
        app_ip_req   = 1'b0;
        app_ip_rel   = 1'b0;
        app_cpu_req  = 1'b0;
        app_cpu_rel  = 1'b0;
        tick(10);
        rst_n = 1'b1;
        run_tx_phase();
        run_rx_phase();
        run_size_phase();
        run_app_phase();
        tick(4);
        finish_run();
    end

    initial begin
        for (int cyc = 0; cyc < TIMEOUT_CYCLES; cyc++) begin
            @(posedge clk);
        end
        errors++;
        $display("Run timed out after %0d cycles with stimulus still pending", TIMEOUT_CYCLES);
        finish_run();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference state and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign size_write = rxbuf_wr.we && (rxbuf_wr.addr == RX_SIZE_WORD_ADDR);
    assign app_idle   = !app_ip_grant && !app_cpu_grant;

    always @(posedge clk) begin
        if (!rst_n) begin
            rel_edges <= 0;
            last_size <= '0;
        end else begin
            rel_edges <= rel_edges + 1;
            if (size_write) begin
                last_size <= rxbuf_wr.wdata.hdr.rx_size;
            end
        end
    end

    a_reset_values: assert property (@(posedge clk) $rose(rst_n) |-> rxbuf_ip_grant
        && !txbuf_ip_grant && app_idle && !led_r && !led_g && !led_b)
        else log_failure("outputs wrong in first cycle after reset");
    a_rx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rxbuf_ip_grant && !rxbuf_ip_rel |=> rxbuf_ip_grant)
        else log_failure("rxbuf grant dropped without an engine release");
    a_rx_drop: assert property (@(posedge clk) disable iff (!rst_n)
        rxbuf_ip_grant && rxbuf_ip_rel |=> !rxbuf_ip_grant)
        else log_failure("rxbuf grant still high after engine release");
    a_rx_low_two: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rxbuf_ip_grant && rxbuf_ip_rel) |=> !rxbuf_ip_grant)
        else log_failure("rxbuf grant low for only one cycle");
    a_rx_back: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rxbuf_ip_grant && rxbuf_ip_rel, 2) |=> rxbuf_ip_grant)
        else log_failure("rxbuf grant not back two cycles after release");
    a_led_model: assert property (@(posedge clk) disable iff (!rst_n)
        {led_r, led_g, led_b} == led_pattern(last_size))
        else log_failure("LEDs do not match the last written size");
    a_led_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !size_write |=> $stable({led_r, led_g, led_b}))
        else log_failure("LEDs changed without a size write");
    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        txbuf_ip_grant && !txbuf_ip_rel |=> txbuf_ip_grant)
        else log_failure("txbuf grant dropped without an engine release");
    a_tx_drop: assert property (@(posedge clk) disable iff (!rst_n)
        txbuf_ip_grant && txbuf_ip_rel |=> !txbuf_ip_grant)
        else log_failure("txbuf grant still high after engine release");
    a_tx_on_period: assert property (@(posedge clk) disable iff (!rst_n) !txbuf_ip_grant
        && (rel_edges % TXBUF_REL_PERIOD == TXBUF_REL_PERIOD - 1) |=> txbuf_ip_grant)
        else log_failure("txbuf grant missed a period boundary");
    a_tx_only_period: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(txbuf_ip_grant) |-> (rel_edges % TXBUF_REL_PERIOD == 0))
        else log_failure("txbuf grant rose off a period boundary");
    a_tx_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        txbuf_rdata == exp_rdata[$past(txbuf_addr)])
        else log_failure("txbuf read data does not match the message table");
    a_app_pick_ip: assert property (@(posedge clk) disable iff (!rst_n)
        app_idle && app_ip_req |=> app_ip_grant)
        else log_failure("app block not granted to IP");
    a_app_pick_cpu: assert property (@(posedge clk) disable iff (!rst_n)
        app_idle && !app_ip_req && app_cpu_req |=> app_cpu_grant)
        else log_failure("app block not granted to host");
    a_app_idle: assert property (@(posedge clk) disable iff (!rst_n)
        app_idle && !app_ip_req && !app_cpu_req |=> app_idle)
        else log_failure("app block granted without a request");
    a_app_ip_hold: assert property (@(posedge clk) disable iff (!rst_n)
        app_ip_grant && !app_ip_rel |=> app_ip_grant)
        else log_failure("IP lost the app block without releasing");
    a_app_ip_done: assert property (@(posedge clk) disable iff (!rst_n)
        app_ip_grant && app_ip_rel |=> app_idle)
        else log_failure("app block not idle after IP release");
    a_app_cpu_hold: assert property (@(posedge clk) disable iff (!rst_n)
        app_cpu_grant && !app_cpu_rel |=> app_cpu_grant)
        else log_failure("host lost the app block without releasing");
    a_app_cpu_done: assert property (@(posedge clk) disable iff (!rst_n)
        app_cpu_grant && app_cpu_rel |=> app_idle)
        else log_failure("app block not idle after host release");
    a_app_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(app_ip_grant && app_cpu_grant))
        else log_failure("both app grants high");

endmodule

// ==== sim.f ====
hw/ros2_buf_pkg.sv
hw/buf_owner_toggle.sv
hw/app_data_arbiter.sv
hw/rxbuf_host_agent.sv
hw/txbuf_host_agent.sv
hw/ros2_buf_host.sv
tb/tb_ros2_buf_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator.
# Exit status is zero only when the testbench reports a clean run.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_ros2_buf_host \
    -f sim.f \
    -o tb_ros2_buf_host
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_ros2_buf_host 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
